// ==== verilog/fold_macros.svh ====
/*
 * Fold statistics sizing: decode window, fold groups, counter kinds and width.
 */
`ifndef FOLD_MACROS_SVH
`define FOLD_MACROS_SVH

// decode slots looked at each cycle
`define FOLD_WINDOW 4

// fold groups 1..9 kept in bits 0..8
`define FOLD_GROUPS 9

// one-hot instruction class width
`define FOLD_TYPE_W 6

// counters kept per group
`define STAT_KINDS 7
`define STAT_CNT_W 16

`endif

// ==== verilog/fold_pkg.sv ====
/*
 * Fold decode types: instruction classes, fold group vector and
 * the number of window slots each fold group consumes.
 */
`default_nettype none

`include "fold_macros.svh"

package fold_pkg;

	// one bit per class with a single bit set on a valid slot
	typedef logic [`FOLD_TYPE_W-1:0] inst_type_t;

	// position of each class inside inst_type_t
	typedef enum logic [2:0] {
		type_nf  = 3'd0,
		type_lv  = 3'd1,
		type_op  = 3'd2,
		type_bg2 = 3'd3,
		type_bg1 = 3'd4,
		type_mem = 3'd5
	} type_bit_e;

	// bit g-1 stands for fold group g
	typedef logic [`FOLD_GROUPS-1:0] group_vec_t;

	// slots used by groups 1..9
	// LV LV OP MEM, then the three-slot groups, then the pairs
	parameter int unsigned group_depth [`FOLD_GROUPS] = '{
		4, 3, 3, 3, 2, 2, 2, 2, 2
	};

endpackage

`default_nettype wire

// ==== verilog/stat_pkg.sv ====
/*
 * Statistics types: counter kinds, counter values, read index and
 * the increment and coverage vectors of the counter bank.
 */
`default_nettype none

`include "fold_macros.svh"

package stat_pkg;

	// order matches the bit position in kind_vec_t and in coverage
	typedef enum logic [2:0] {
		kind_folded      = 3'd0,
		kind_missed      = 3'd1,
		kind_fle_off     = 3'd2,
		kind_ib_dirty    = 3'd3,
		kind_scache_miss = 3'd4,
		kind_squash      = 3'd5,
		kind_dec_invalid = 3'd6
	} stat_kind_e;

	typedef logic [`STAT_CNT_W-1:0] stat_cnt_t;
	typedef logic [3:0] group_idx_t;
	typedef logic [`STAT_KINDS-1:0] kind_vec_t;

	// one kind vector per fold group
	typedef kind_vec_t [`FOLD_GROUPS-1:0] stat_incr_t;

	// bit group*7 + kind
	typedef logic [`FOLD_GROUPS*`STAT_KINDS-1:0] cover_vec_t;

endpackage

`default_nettype wire

// ==== verilog/fold_ideal_detect.sv ====
/*
 * Ideal fold detection: matches the four-slot decode window against
 * the nine fold patterns, with group 1 over 2 and group 4 over 7.
 */
`timescale 1ns/10ps
`default_nettype none

`include "fold_macros.svh"

module fold_ideal_detect (
	input  fold_pkg::inst_type_t inst_type [`FOLD_WINDOW],
	input  logic                 inst_valid [`FOLD_WINDOW],
	output fold_pkg::group_vec_t ideal_group
);

	import fold_pkg::*;

	// per-slot class hits qualified by slot valid
	logic [`FOLD_WINDOW-1:0] lv;
	logic [`FOLD_WINDOW-1:0] op;
	logic [`FOLD_WINDOW-1:0] bg2;
	logic [`FOLD_WINDOW-1:0] bg1;
	logic [`FOLD_WINDOW-1:0] mem;

	// pattern hits before suppression
	group_vec_t match;

	always_comb begin
		for (int i = 0; i < `FOLD_WINDOW; i++) begin
			lv[i]  = inst_valid[i] & inst_type[i][type_lv];
			op[i]  = inst_valid[i] & inst_type[i][type_op];
			bg2[i] = inst_valid[i] & inst_type[i][type_bg2];
			bg1[i] = inst_valid[i] & inst_type[i][type_bg1];
			mem[i] = inst_valid[i] & inst_type[i][type_mem];
		end
	end

	assign match[0] = lv[0] & lv[1] & op[2] & mem[3];
	assign match[1] = lv[0] & lv[1] & op[2];
	assign match[2] = lv[0] & lv[1] & bg2[2];
	assign match[3] = lv[0] & op[1] & mem[2];
	assign match[4] = lv[0] & bg2[1];
	assign match[5] = lv[0] & bg1[1];
	assign match[6] = lv[0] & op[1];
	assign match[7] = lv[0] & mem[1];
	assign match[8] = op[0] & mem[1];

	always_comb begin
		ideal_group = match;
		// longer fold shadows its own prefix
		ideal_group[1] = match[1] & ~match[0];
		ideal_group[6] = match[6] & ~match[3];
	end

	// decoder must hand over a single class on every valid slot
	always_comb begin
		for (int i = 0; i < `FOLD_WINDOW; i++) begin
			if (inst_valid[i]) begin
				a_slot_onehot: assert final ($onehot(inst_type[i]))
					else $error("decode slot %0d class %b not one-hot", i, inst_type[i]);
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/fold_miss_classify.sv ====
/*
 * Miss classification: compares ideal and actual fold groups on an
 * advancing cycle and sorts each miss by cause into counter increments.
 */
`timescale 1ns/10ps
`default_nettype none

`include "fold_macros.svh"

module fold_miss_classify (
	input  fold_pkg::group_vec_t ideal_group,
	input  fold_pkg::group_vec_t fold_group,
	input  logic                 hold_r,
	input  logic                 hold_d,
	input  logic                 hold_e,
	input  logic                 hold_c,
	input  logic                 psr_fle,
	input  logic                 scache_miss,
	input  logic                 vld_drty_entries,
	input  logic                 squash_fold,
	input  logic                 dec_valid [`FOLD_WINDOW],
	output stat_pkg::stat_incr_t incr,
	output logic                 unexplained
);

	import fold_pkg::*;
	import stat_pkg::*;

	logic       advance;
	logic       any_cause;
	group_vec_t missed;
	// a slot the group needs was not decoded
	group_vec_t dec_short;
	// miss with no cause and a fully decoded window
	group_vec_t orphan;

	// nothing counts while any stage holds
	assign advance = ~(hold_r | hold_d | hold_e | hold_c);

	assign any_cause = ~psr_fle | scache_miss | vld_drty_entries | squash_fold;

	assign missed = advance ? (ideal_group & ~fold_group) : '0;

	always_comb begin
		for (int g = 0; g < `FOLD_GROUPS; g++) begin
			dec_short[g] = 1'b0;
			for (int s = 0; s < `FOLD_WINDOW; s++) begin
				if (s < group_depth[g] && !dec_valid[s]) begin
					dec_short[g] = 1'b1;
				end
			end
		end
	end

	always_comb begin
		for (int g = 0; g < `FOLD_GROUPS; g++) begin
			incr[g][kind_folded] = advance & fold_group[g];
			incr[g][kind_missed] = missed[g];

			// causes are counted independently of each other
			incr[g][kind_fle_off]     = missed[g] & ~psr_fle;
			incr[g][kind_scache_miss] = missed[g] & scache_miss;
			incr[g][kind_ib_dirty]    = missed[g] & vld_drty_entries;
			incr[g][kind_squash]      = missed[g] & squash_fold;

			incr[g][kind_dec_invalid] = missed[g] & ~any_cause & dec_short[g];
			orphan[g] = missed[g] & ~any_cause & ~dec_short[g];
		end
	end

	assign unexplained = |orphan;

	// folding logic picks at most one group per advancing cycle
	always_comb begin
		a_fold_onehot: assert final (!advance || $onehot0(fold_group))
			else $error("fold_group %b has several groups set", fold_group);
	end

endmodule

`default_nettype wire

// ==== verilog/fold_stat_counters.sv ====
/*
 * Statistics counter bank: 9 groups x 7 kinds of 16-bit wrapping
 * counters, plus the registered unexplained-miss pulse.
 */
`timescale 1ns/10ps
`default_nettype none

`include "fold_macros.svh"

module fold_stat_counters (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stat_enable,
	input  logic                 clr_pulse,
	input  stat_pkg::stat_incr_t incr,
	input  logic                 unexplained,
	output stat_pkg::stat_cnt_t  cnt [`FOLD_GROUPS][`STAT_KINDS],
	output logic                 unexplained_miss
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '{default: '0};
		end else if (clr_pulse) begin
			// clear beats any increment on the same edge
			cnt <= '{default: '0};
		end else if (stat_enable) begin
			for (int g = 0; g < `FOLD_GROUPS; g++) begin
				for (int k = 0; k < `STAT_KINDS; k++) begin
					if (incr[g][k]) begin
						cnt[g][k] <= cnt[g][k] + 1'b1;
					end
				end
			end
		end
	end

	// one-cycle flag while statistics are on
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			unexplained_miss <= 1'b0;
		end else begin
			unexplained_miss <= stat_enable & unexplained;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/fold_stat_regs.sv ====
/*
 * Statistics configuration and read-out: registers enable and clear,
 * returns one addressed counter and the non-zero coverage vector.
 */
`timescale 1ns/10ps
`default_nettype none

`include "fold_macros.svh"

module fold_stat_regs (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cfg_enable,
	input  logic                 clear,
	input  stat_pkg::group_idx_t rd_group,
	input  stat_pkg::stat_kind_e rd_kind,
	input  stat_pkg::stat_cnt_t  cnt [`FOLD_GROUPS][`STAT_KINDS],
	output logic                 stat_enable,
	output logic                 clr_pulse,
	output stat_pkg::stat_cnt_t  rd_data,
	output stat_pkg::cover_vec_t coverage
);

	import stat_pkg::*;

	stat_cnt_t  rd_sel;
	cover_vec_t nonzero;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stat_enable <= 1'b0;
			clr_pulse   <= 1'b0;
		end else begin
			stat_enable <= cfg_enable;
			clr_pulse   <= clear;
		end
	end

	// out of range address reads as zero
	assign rd_sel = (rd_group < `FOLD_GROUPS && rd_kind < `STAT_KINDS) ?
		cnt[rd_group][rd_kind] : '0;

	always_comb begin
		for (int g = 0; g < `FOLD_GROUPS; g++) begin
			for (int k = 0; k < `STAT_KINDS; k++) begin
				nonzero[g*`STAT_KINDS + k] = |cnt[g][k];
			end
		end
	end

	// both outputs lag the counter bank by one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_data  <= '0;
			coverage <= '0;
		end else begin
			rd_data  <= rd_sel;
			coverage <= nonzero;
		end
	end

	a_rd_group_range: assert property (@(posedge clk) disable iff (!rst_n)
		rd_group < `FOLD_GROUPS)
		else $error("rd_group %0d beyond last fold group", rd_group);

	// clear reaches the bank one edge later and coverage one edge after that
	a_clear_coverage: assert property (@(posedge clk) disable iff (!rst_n)
		clr_pulse |=> ##1 (coverage == '0))
		else $error("coverage %h not cleared after clear", coverage);

endmodule

`default_nettype wire

// ==== verilog/fold_monitor_top.sv ====
/*
 * Folding statistics unit: ideal fold detection, miss sorting,
 * counter bank and configuration/read-out registers.
 */
`timescale 1ns/10ps
`default_nettype none

`include "fold_macros.svh"

module fold_monitor_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  fold_pkg::inst_type_t inst_type [`FOLD_WINDOW],
	input  logic                 inst_valid [`FOLD_WINDOW],
	input  fold_pkg::group_vec_t fold_group,
	input  logic                 hold_r,
	input  logic                 hold_d,
	input  logic                 hold_e,
	input  logic                 hold_c,
	input  logic                 psr_fle,
	input  logic                 scache_miss,
	input  logic                 vld_drty_entries,
	input  logic                 squash_fold,
	input  logic                 dec_valid [`FOLD_WINDOW],
	input  logic                 cfg_enable,
	input  logic                 clear,
	input  stat_pkg::group_idx_t rd_group,
	input  stat_pkg::stat_kind_e rd_kind,
	output stat_pkg::stat_cnt_t  rd_data,
	output stat_pkg::cover_vec_t coverage,
	output logic                 unexplained_miss
);

	import fold_pkg::*;
	import stat_pkg::*;

	group_vec_t ideal_group;
	stat_incr_t incr;
	logic       unexplained;
	logic       stat_enable;
	logic       clr_pulse;
	stat_cnt_t  cnt [`FOLD_GROUPS][`STAT_KINDS];

	fold_ideal_detect u_detect (
		.inst_type   (inst_type),
		.inst_valid  (inst_valid),
		.ideal_group (ideal_group)
	);

	fold_miss_classify u_classify (
		.ideal_group      (ideal_group),
		.fold_group       (fold_group),
		.hold_r           (hold_r),
		.hold_d           (hold_d),
		.hold_e           (hold_e),
		.hold_c           (hold_c),
		.psr_fle          (psr_fle),
		.scache_miss      (scache_miss),
		.vld_drty_entries (vld_drty_entries),
		.squash_fold      (squash_fold),
		.dec_valid        (dec_valid),
		.incr             (incr),
		.unexplained      (unexplained)
	);

	fold_stat_counters u_counters (
		.clk              (clk),
		.rst_n            (rst_n),
		.stat_enable      (stat_enable),
		.clr_pulse        (clr_pulse),
		.incr             (incr),
		.unexplained      (unexplained),
		.cnt              (cnt),
		.unexplained_miss (unexplained_miss)
	);

	fold_stat_regs u_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.cfg_enable  (cfg_enable),
		.clear       (clear),
		.rd_group    (rd_group),
		.rd_kind     (rd_kind),
		.cnt         (cnt),
		.stat_enable (stat_enable),
		.clr_pulse   (clr_pulse),
		.rd_data     (rd_data),
		.coverage    (coverage)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_fold_monitor.sv ====
/*
 * Fold monitor testbench: directed and random decode windows against
 * a counter model, checked through the read port and coverage.
 */
`timescale 1ns/10ps
`default_nettype none

`include "fold_macros.svh"

module tb_fold_monitor;

	import fold_pkg::*;
	import stat_pkg::*;

	// the tests run for about 900 cycles
	localparam int max_cycles = 6000;

	localparam logic [5:0] c_nf  = 6'b000001;
	localparam logic [5:0] c_lv  = 6'b000010;
	localparam logic [5:0] c_op  = 6'b000100;
	localparam logic [5:0] c_bg2 = 6'b001000;
	localparam logic [5:0] c_bg1 = 6'b010000;
	localparam logic [5:0] c_mem = 6'b100000;

	// fold patterns per group and slot
	localparam logic [5:0] pat [9][4] = '{
		'{c_lv, c_lv, c_op, c_mem}, '{c_lv, c_lv, c_op, 6'd0}, '{c_lv, c_lv, c_bg2, 6'd0},
		'{c_lv, c_op, c_mem, 6'd0}, '{c_lv, c_bg2, 6'd0, 6'd0}, '{c_lv, c_bg1, 6'd0, 6'd0},
		'{c_lv, c_op, 6'd0, 6'd0}, '{c_lv, c_mem, 6'd0, 6'd0}, '{c_op, c_mem, 6'd0, 6'd0}
	};
	localparam int pat_len [9] = '{4, 3, 3, 3, 2, 2, 2, 2, 2};

	logic       clk = 1'b0;
	logic       rst_n;
	inst_type_t inst_type [`FOLD_WINDOW];
	logic       inst_valid [`FOLD_WINDOW];
	group_vec_t fold_group;
	logic       hold_r;
	logic       hold_d;
	logic       hold_e;
	logic       hold_c;
	logic       psr_fle;
	logic       scache_miss;
	logic       vld_drty_entries;
	logic       squash_fold;
	logic       dec_valid [`FOLD_WINDOW];
	logic       cfg_enable;
	logic       clear;
	group_idx_t rd_group;
	stat_kind_e rd_kind;
	stat_cnt_t  rd_data;
	cover_vec_t coverage;
	logic       unexplained_miss;

	// reference model state
	logic [15:0] exp_cnt [9][7] = '{default: '0};
	logic        en_q = 1'b0;
	logic        clr_q = 1'b0;
	logic        exp_unexp = 1'b0;

	integer seed = 32'hf37e_7732;
	int     errors = 0;
	int     checks = 0;
	int     cycle_count = 0;

	fold_monitor_top uut (
		.clk(clk), .rst_n(rst_n), .inst_type(inst_type), .inst_valid(inst_valid),
		.fold_group(fold_group), .hold_r(hold_r), .hold_d(hold_d), .hold_e(hold_e),
		.hold_c(hold_c), .psr_fle(psr_fle), .scache_miss(scache_miss),
		.vld_drty_entries(vld_drty_entries), .squash_fold(squash_fold),
		.dec_valid(dec_valid), .cfg_enable(cfg_enable), .clear(clear),
		.rd_group(rd_group), .rd_kind(rd_kind), .rd_data(rd_data),
		.coverage(coverage), .unexplained_miss(unexplained_miss)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("run stopped, no result after %0d cycles", cycle_count);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic logic [8:0] ideal_groups();
		logic [8:0] hit;
		for (int g = 0; g < 9; g++) begin
			hit[g] = 1'b1;
			for (int s = 0; s < pat_len[g]; s++) begin
				if (!inst_valid[s] || inst_type[s] != pat[g][s]) begin
					hit[g] = 1'b0;
				end
			end
		end
		// the longer fold hides its prefix
		if (hit[0]) begin
			hit[1] = 1'b0;
		end
		if (hit[3]) begin
			hit[6] = 1'b0;
		end
		return hit;
	endfunction

	// mirrors one rising edge of the unit
	task automatic predict_edge();
		logic [8:0] ideal;
		logic [6:0] inc [9];
		logic       adv;
		logic       cause;
		logic       short_dec;
		logic       orphan;
		ideal = ideal_groups();
		adv = !(hold_r || hold_d || hold_e || hold_c);
		cause = !psr_fle || scache_miss || vld_drty_entries || squash_fold;
		orphan = 1'b0;
		for (int g = 0; g < 9; g++) begin
			inc[g] = '0;
			inc[g][kind_folded] = adv && fold_group[g];
			if (adv && ideal[g] && !fold_group[g]) begin
				inc[g][kind_missed] = 1'b1;
				inc[g][kind_fle_off] = !psr_fle;
				inc[g][kind_scache_miss] = scache_miss;
				inc[g][kind_ib_dirty] = vld_drty_entries;
				inc[g][kind_squash] = squash_fold;
				short_dec = 1'b0;
				for (int s = 0; s < pat_len[g]; s++) begin
					short_dec = short_dec || !dec_valid[s];
				end
				inc[g][kind_dec_invalid] = !cause && short_dec;
				orphan = orphan || (!cause && !short_dec);
			end
		end
		exp_unexp = en_q && orphan;
		for (int g = 0; g < 9; g++) begin
			for (int k = 0; k < 7; k++) begin
				if (clr_q) begin
					exp_cnt[g][k] = '0;
				end else if (en_q && inc[g][k]) begin
					exp_cnt[g][k] = exp_cnt[g][k] + 16'd1;
				end
			end
		end
		en_q = cfg_enable;
		clr_q = clear;
	endtask

	task automatic advance_clock();
		@(posedge clk);
		predict_edge();
		#5;
		checks++;
		if (unexplained_miss !== exp_unexp) begin
			$display("CHECK FAILED unexplained_miss: expected %h, got %h", exp_unexp,
				unexplained_miss);
			errors++;
		end
	endtask

	task automatic quiet();
		for (int s = 0; s < `FOLD_WINDOW; s++) begin
			inst_type[s] = c_nf;
			inst_valid[s] = 1'b0;
			dec_valid[s] = 1'b1;
		end
		fold_group = '0;
		{hold_r, hold_d, hold_e, hold_c} = 4'b0000;
		{psr_fle, scache_miss, vld_drty_entries, squash_fold} = 4'b1000;
	endtask

	task automatic set_window(input logic [5:0] c0, c1, c2, c3, input logic [3:0] v);
		inst_type[0] = c0;
		inst_type[1] = c1;
		inst_type[2] = c2;
		inst_type[3] = c3;
		for (int s = 0; s < `FOLD_WINDOW; s++) begin
			inst_valid[s] = v[s];
		end
	endtask

	task automatic read_counter(input int g, input int k, input logic [15:0] expected);
		rd_group = g[3:0];
		rd_kind = stat_kind_e'(k);
		advance_clock();
		checks++;
		if (rd_data !== expected) begin
			$display("CHECK FAILED rd_data group %0d kind %0d: expected %h, got %h", g, k,
				expected, rd_data);
			errors++;
		end
	endtask

	// one idle cycle so coverage catches up and then every counter
	task automatic check_all();
		cover_vec_t exp_cov;
		quiet();
		advance_clock();
		for (int g = 0; g < 9; g++) begin
			for (int k = 0; k < 7; k++) begin
				exp_cov[g*7 + k] = (exp_cnt[g][k] != 16'd0);
			end
		end
		checks++;
		if (coverage !== exp_cov) begin
			$display("CHECK FAILED coverage: expected %h, got %h", exp_cov, coverage);
			errors++;
		end
		for (int g = 0; g < 9; g++) begin
			for (int k = 0; k < 7; k++) begin
				read_counter(g, k, exp_cnt[g][k]);
			end
		end
	endtask

	task automatic report_test(input string name, input int err0);
		if (errors == err0) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - err0);
		end
	endtask

	task automatic reset_values();
		int err0 = errors;
		check_all();
		report_test("reset", err0);
	endtask

	task automatic folded_counts();
		int err0 = errors;
		cfg_enable = 1'b1;
		advance_clock();
		for (int i = 0; i < 4; i++) begin
			fold_group = 9'd1 << (2*i);
			repeat (i + 2) advance_clock();
			// stalled cycle is not counted
			hold_e = 1'b1;
			advance_clock();
			hold_e = 1'b0;
		end
		check_all();
		for (int i = 0; i < 4; i++) begin
			read_counter(2*i, kind_folded, 16'(i + 2));
		end
		report_test("folded counts", err0);
	endtask

	task automatic suppression_causes();
		int err0 = errors;
		set_window(c_lv, c_lv, c_op, c_mem, 4'b1111);
		psr_fle = 1'b0;
		scache_miss = 1'b1;
		repeat (3) advance_clock();
		hold_d = 1'b1;
		advance_clock();
		check_all();
		read_counter(0, kind_missed, 16'd3);
		read_counter(0, kind_fle_off, 16'd3);
		read_counter(0, kind_scache_miss, 16'd3);
		read_counter(1, kind_missed, 16'd0);
		report_test("suppression and causes", err0);
	endtask

	task automatic decode_unexplained();
		int err0 = errors;
		int pulses = 0;
		set_window(c_lv, c_bg2, c_nf, c_nf, 4'b0011);
		dec_valid[1] = 1'b0;
		repeat (2) advance_clock();
		dec_valid[1] = 1'b1;
		advance_clock();
		pulses += unexplained_miss;
		quiet();
		advance_clock();
		pulses += unexplained_miss;
		if (pulses != 1) begin
			$display("unexplained_miss pulsed %0d times instead of once", pulses);
			errors++;
		end
		check_all();
		read_counter(4, kind_dec_invalid, 16'd2);
		read_counter(4, kind_missed, 16'd3);
		report_test("decode cause and unexplained", err0);
	endtask

	task automatic enable_clear();
		int err0 = errors;
		cfg_enable = 1'b0;
		advance_clock();
		fold_group = 9'd1 << 7;
		repeat (3) advance_clock();
		check_all();
		read_counter(7, kind_folded, 16'd0);
		clear = 1'b1;
		advance_clock();
		clear = 1'b0;
		advance_clock();
		check_all();
		if (coverage !== '0) begin
			$display("CHECK FAILED coverage: expected %h, got %h", 63'd0, coverage);
			errors++;
		end
		cfg_enable = 1'b1;
		report_test("enable and clear", err0);
	endtask

	task automatic random_windows();
		int err0 = errors;
		int v;
		logic [5:0] pick [8] = '{c_lv, c_lv, c_lv, c_op, c_mem, c_bg2, c_bg1, c_nf};
		repeat (400) begin
			for (int s = 0; s < `FOLD_WINDOW; s++) begin
				inst_type[s] = pick[$unsigned($random(seed)) % 8];
				inst_valid[s] = ($random(seed) & 7) != 0;
				dec_valid[s] = ($random(seed) & 7) != 0;
			end
			v = $unsigned($random(seed)) % 12;
			fold_group = '0;
			if (v < 9) begin
				fold_group[v] = 1'b1;
			end
			{hold_r, hold_d} = {($random(seed) & 15) == 0, ($random(seed) & 15) == 0};
			{hold_e, hold_c} = {($random(seed) & 15) == 0, ($random(seed) & 15) == 0};
			psr_fle = ($random(seed) & 7) != 0;
			scache_miss = ($random(seed) & 7) == 0;
			vld_drty_entries = ($random(seed) & 7) == 0;
			squash_fold = ($random(seed) & 7) == 0;
			advance_clock();
		end
		check_all();
		report_test("random windows", err0);
	endtask

	initial begin
		rst_n = 1'b0;
		cfg_enable = 1'b0;
		clear = 1'b0;
		rd_group = '0;
		rd_kind = kind_folded;
		quiet();
		repeat (2) @(posedge clk);
		#5;
		rst_n = 1'b1;
		reset_values();
		folded_counts();
		suppression_causes();
		decode_unexplained();
		enable_clear();
		random_windows();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verilog
verilog/fold_pkg.sv
verilog/stat_pkg.sv
verilog/fold_ideal_detect.sv
verilog/fold_miss_classify.sv
verilog/fold_stat_counters.sv
verilog/fold_stat_regs.sv
verilog/fold_monitor_top.sv
testbench/tb_fold_monitor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fold monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module tb_fold_monitor \
	-Mdir obj_dir -o tb_fold_monitor

out=$(./obj_dir/tb_fold_monitor 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Done: no errors"; then
	exit 0
else
	exit 1
fi
